//--- rtl/cpuDecodePkg.sv
`default_nettype none

package cpuDecodePkg;

	localparam int numDecodeLines = 16;

	typedef logic [7:0] opcode_t;
	typedef logic [numDecodeLines-1:0] decodeVec_t;

	typedef enum logic [2:0] {
		classImp,
		classLdaImm,
		classAndImm,
		classLdaZp,
		classLdaAbs,
		classStaAbs,
		classJmpAbs
	} insClass_e;

	// T1 is the opcode fetch and T0 closes every instruction but the jump.
	typedef enum logic [2:0] {
		T0 = 3'd0,
		T1 = 3'd1,
		T2 = 3'd2,
		T3 = 3'd3
	} mCycle_e;

	// **************************************************
	// opcodes of the supported classes.
	// **************************************************
	localparam opcode_t opImp    = 8'h8A;
	localparam opcode_t opLdaImm = 8'hA9;
	localparam opcode_t opAndImm = 8'h29;
	localparam opcode_t opLdaZp  = 8'hA5;
	localparam opcode_t opLdaAbs = 8'hAD;
	localparam opcode_t opStaAbs = 8'h8D;
	localparam opcode_t opJmpAbs = 8'h4C;

	// the decode lines sit at these bit positions and bits 10 to 15 are spare.
	localparam int dImplied = 0;
	localparam int dImm     = 1;
	localparam int dZp2     = 2;
	localparam int dAbs2    = 3;
	localparam int dAbs3    = 4;
	localparam int dStaW    = 5;
	localparam int dLda     = 6;
	localparam int dAnd     = 7;
	localparam int dJmp3    = 8;
	localparam int dFetch   = 9;

	// any byte outside the table behaves as an implied operation.
	function automatic insClass_e classify(input opcode_t op);
		insClass_e cls;
		case (op)
			opImp:    cls = classImp;
			opLdaImm: cls = classLdaImm;
			opAndImm: cls = classAndImm;
			opLdaZp:  cls = classLdaZp;
			opLdaAbs: cls = classLdaAbs;
			opStaAbs: cls = classStaAbs;
			opJmpAbs: cls = classJmpAbs;
			default:  cls = classImp;
		endcase
		return cls;
	endfunction

endpackage

`default_nettype wire

//--- rtl/busCtrlPkg.sv
`default_nettype none

package busCtrlPkg;

	localparam int numStrobes = 12;

	// one bit per register transfer strobe.
	typedef logic [numStrobes-1:0] strobeVec_t;

	// **************************************************
	// accumulator and special bus transfers.
	// **************************************************
	localparam int sSbAc   = 0;
	localparam int sAcSb   = 1;
	localparam int sSbDb   = 2;
	localparam int sAcDb   = 3;

	// **************************************************
	// data latch transfers.
	// **************************************************
	localparam int sDlDb   = 4;
	localparam int sDlAdl  = 5;
	localparam int sDlAdh  = 6;

	// **************************************************
	// address buffers and page forcing.
	// **************************************************
	localparam int sAdlAbl  = 7;
	localparam int sAdhAbh  = 8;
	localparam int sZAdh0   = 9;
	localparam int sZAdh17  = 10;
	localparam int sSbAdh   = 11;

endpackage

`default_nettype wire

//--- rtl/decodeIf.sv
`timescale 1ns/1ps
`default_nettype none

interface decodeIf;

	cpuDecodePkg::decodeVec_t lines;
	cpuDecodePkg::mCycle_e cycle;
	logic lastCycle;
	// readyQ is ready as seen in the previous clock and is low in a repeated cycle.
	logic readyQ;

	modport timing (
		output cycle,
		output lastCycle,
		output readyQ
	);

	modport pla (
		input  cycle,
		output lines
	);

	modport bus (
		input lines,
		input cycle,
		input lastCycle,
		input readyQ
	);

endinterface

`default_nettype wire

//--- rtl/timingGen.sv
`timescale 1ns/1ps
`default_nettype none

module timingGen (
	input  logic phi0,
	input  logic rstN,
	input  logic ready,
	input  cpuDecodePkg::opcode_t dataIn,
	decodeIf.timing tif,
	output cpuDecodePkg::opcode_t insReg,
	output logic sync
);

	cpuDecodePkg::insClass_e insClass;
	cpuDecodePkg::insClass_e fetchClass;
	cpuDecodePkg::mCycle_e cycleQ;
	cpuDecodePkg::mCycle_e cycleNext;
	logic fetchShort;
	logic lastCyc;
	logic readyQ;

	// two cycle instructions go straight from the fetch to T0.
	function automatic logic shortIns(input cpuDecodePkg::insClass_e cls);
		return (cls == cpuDecodePkg::classImp) || (cls == cpuDecodePkg::classLdaImm) ||
			(cls == cpuDecodePkg::classAndImm);
	endfunction

	assign insClass   = cpuDecodePkg::classify(insReg);
	assign fetchClass = cpuDecodePkg::classify(dataIn);
	assign fetchShort = shortIns(fetchClass);

	// the jump ends in T3 and everything else ends in T0.
	assign lastCyc = (cycleQ == cpuDecodePkg::T0) ||
		((cycleQ == cpuDecodePkg::T3) && (insClass == cpuDecodePkg::classJmpAbs));

	always_comb begin
		cycleNext = cpuDecodePkg::T1;
		if (!lastCyc) begin
			case (cycleQ)
				cpuDecodePkg::T1: cycleNext = fetchShort ? cpuDecodePkg::T0 : cpuDecodePkg::T2;
				cpuDecodePkg::T2: cycleNext = (insClass == cpuDecodePkg::classLdaZp) ?
					cpuDecodePkg::T0 : cpuDecodePkg::T3;
				cpuDecodePkg::T3: cycleNext = cpuDecodePkg::T0;
				default:          cycleNext = cpuDecodePkg::T1;
			endcase
		end
	end

	// **************************************************
	// cycle state, instruction register and ready latch.
	// **************************************************
	always_ff @(posedge phi0 or negedge rstN) begin
		if (!rstN) begin
			cycleQ <= cpuDecodePkg::T1;
			insReg <= cpuDecodePkg::opImp;
			readyQ <= 1'b1;
		end else begin
			readyQ <= ready;
			if (ready) begin
				cycleQ <= cycleNext;
				if (cycleQ == cpuDecodePkg::T1) begin
					insReg <= dataIn;
				end
			end
		end
	end

	assign tif.cycle     = cycleQ;
	assign tif.lastCycle = lastCyc;
	assign tif.readyQ    = readyQ;
	assign sync          = (cycleQ == cpuDecodePkg::T1);

endmodule

`default_nettype wire

//--- rtl/decodePla.sv
`timescale 1ns/1ps
`default_nettype none

module decodePla (
	input cpuDecodePkg::opcode_t insReg,
	decodeIf.pla pif
);

	cpuDecodePkg::insClass_e insClass;
	cpuDecodePkg::decodeVec_t lines;

	logic cT0;
	logic cT1;
	logic cT2;
	logic cT3;

	logic isImp;
	logic isLdaImm;
	logic isAndImm;
	logic isLdaZp;
	logic isLdaAbs;
	logic isStaAbs;
	logic isJmpAbs;
	logic isAbs;

	assign insClass = cpuDecodePkg::classify(insReg);

	// **************************************************
	// cycle terms.
	// **************************************************
	assign cT0 = (pif.cycle == cpuDecodePkg::T0);
	assign cT1 = (pif.cycle == cpuDecodePkg::T1);
	assign cT2 = (pif.cycle == cpuDecodePkg::T2);
	assign cT3 = (pif.cycle == cpuDecodePkg::T3);

	// **************************************************
	// class terms.
	// **************************************************
	assign isImp    = (insClass == cpuDecodePkg::classImp);
	assign isLdaImm = (insClass == cpuDecodePkg::classLdaImm);
	assign isAndImm = (insClass == cpuDecodePkg::classAndImm);
	assign isLdaZp  = (insClass == cpuDecodePkg::classLdaZp);
	assign isLdaAbs = (insClass == cpuDecodePkg::classLdaAbs);
	assign isStaAbs = (insClass == cpuDecodePkg::classStaAbs);
	assign isJmpAbs = (insClass == cpuDecodePkg::classJmpAbs);
	assign isAbs    = isLdaAbs | isStaAbs | isJmpAbs;

	// each line is one product term of class and cycle while spare lines stay low.
	always_comb begin
		lines = '0;
		lines[cpuDecodePkg::dImplied] = isImp & cT0;
		lines[cpuDecodePkg::dImm]     = (isLdaImm | isAndImm) & cT0;
		lines[cpuDecodePkg::dZp2]     = isLdaZp & cT2;
		lines[cpuDecodePkg::dAbs2]    = isAbs & cT2;
		lines[cpuDecodePkg::dAbs3]    = isAbs & cT3;
		lines[cpuDecodePkg::dStaW]    = isStaAbs & cT3;
		lines[cpuDecodePkg::dLda]     = (isLdaZp | isLdaAbs) & cT0;
		lines[cpuDecodePkg::dAnd]     = isAndImm & cT0;
		lines[cpuDecodePkg::dJmp3]    = isJmpAbs & cT3;
		lines[cpuDecodePkg::dFetch]   = cT1;
	end

	assign pif.lines = lines;

endmodule

`default_nettype wire

//--- rtl/busControl.sv
`timescale 1ns/1ps
`default_nettype none

module busControl (
	input  logic phi0,
	input  logic rstN,
	decodeIf.bus bif,
	output busCtrlPkg::strobeVec_t strobes
);

	logic lnImplied;
	logic lnImm;
	logic lnZp2;
	logic lnAbs2;
	logic lnAbs3;
	logic lnStaW;
	logic lnLda;
	logic lnAnd;
	logic lnJmp3;
	logic lnFetch;

	logic nDlAdl;
	logic pageZero;
	logic nZAdh17;
	logic nSbAc;
	logic nAcSb;
	logic nDlDb;
	logic nStore;
	logic nAdlAbl;
	logic nAdhAbh;

	busCtrlPkg::strobeVec_t strobeNext;

	assign lnImplied = bif.lines[cpuDecodePkg::dImplied];
	assign lnImm     = bif.lines[cpuDecodePkg::dImm];
	assign lnZp2     = bif.lines[cpuDecodePkg::dZp2];
	assign lnAbs2    = bif.lines[cpuDecodePkg::dAbs2];
	assign lnAbs3    = bif.lines[cpuDecodePkg::dAbs3];
	assign lnStaW    = bif.lines[cpuDecodePkg::dStaW];
	assign lnLda     = bif.lines[cpuDecodePkg::dLda];
	assign lnAnd     = bif.lines[cpuDecodePkg::dAnd];
	assign lnJmp3    = bif.lines[cpuDecodePkg::dJmp3];
	assign lnFetch   = bif.lines[cpuDecodePkg::dFetch];

	// **************************************************
	// address low from the data latch.
	// **************************************************
	assign nDlAdl   = ~(lnZp2 | lnAbs2);
	assign pageZero = ~(nDlAdl | lnAbs2);
	assign nZAdh17  = ~(pageZero & (bif.cycle == cpuDecodePkg::T2));

	// accumulator loads only complete in the last cycle.
	assign nSbAc  = ~(bif.lastCycle & (lnImm | lnLda | lnImplied));
	assign nAcSb  = ~(lnImplied | lnAnd);
	assign nDlDb  = ~(bif.lastCycle & (lnImm | lnLda));
	assign nStore = ~lnStaW;

	// a repeated cycle keeps the address buffers closed.
	assign nAdlAbl = ~((lnFetch | lnZp2 | lnAbs2) & bif.readyQ);
	assign nAdhAbh = ~((lnFetch | lnZp2 | lnAbs3) & bif.readyQ);

	always_comb begin
		strobeNext = '0;
		strobeNext[busCtrlPkg::sSbAc]   = ~nSbAc;
		strobeNext[busCtrlPkg::sAcSb]   = ~nAcSb;
		strobeNext[busCtrlPkg::sSbDb]   = ~nStore;
		strobeNext[busCtrlPkg::sAcDb]   = ~nStore;
		strobeNext[busCtrlPkg::sDlDb]   = ~nDlDb;
		strobeNext[busCtrlPkg::sDlAdl]  = ~nDlAdl;
		strobeNext[busCtrlPkg::sDlAdh]  = lnAbs3;
		strobeNext[busCtrlPkg::sAdlAbl] = ~nAdlAbl;
		strobeNext[busCtrlPkg::sAdhAbh] = ~nAdhAbh;
		strobeNext[busCtrlPkg::sZAdh0]  = pageZero;
		strobeNext[busCtrlPkg::sZAdh17] = ~nZAdh17;
		strobeNext[busCtrlPkg::sSbAdh]  = lnJmp3;
	end

	// **************************************************
	// strobe register, one clock behind the decode.
	// **************************************************
	always_ff @(posedge phi0 or negedge rstN) begin
		if (!rstN) begin
			strobes <= '0;
		end else begin
			strobes <= strobeNext;
		end
	end

endmodule

`default_nettype wire

//--- rtl/cpuControlTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuControlTop (
	input  logic phi0,
	input  logic rstN,
	input  logic ready,
	input  cpuDecodePkg::opcode_t dataIn,
	output logic sbAc,
	output logic acSb,
	output logic sbDb,
	output logic acDb,
	output logic dlDb,
	output logic dlAdl,
	output logic dlAdh,
	output logic adlAbl,
	output logic adhAbh,
	output logic zAdh0,
	output logic zAdh17,
	output logic sbAdh,
	output logic sync,
	output cpuDecodePkg::mCycle_e cycle
);

	cpuDecodePkg::opcode_t insReg;
	busCtrlPkg::strobeVec_t strobes;

	decodeIf dif ();

	timingGen timingGen_i (
		.phi0   (phi0),
		.rstN   (rstN),
		.ready  (ready),
		.dataIn (dataIn),
		.tif    (dif.timing),
		.insReg (insReg),
		.sync   (sync)
	);

	decodePla decodePla_i (
		.insReg (insReg),
		.pif    (dif.pla)
	);

	busControl busControl_i (
		.phi0    (phi0),
		.rstN    (rstN),
		.bif     (dif.bus),
		.strobes (strobes)
	);

	assign cycle  = dif.cycle;

	assign sbAc   = strobes[busCtrlPkg::sSbAc];
	assign acSb   = strobes[busCtrlPkg::sAcSb];
	assign sbDb   = strobes[busCtrlPkg::sSbDb];
	assign acDb   = strobes[busCtrlPkg::sAcDb];
	assign dlDb   = strobes[busCtrlPkg::sDlDb];
	assign dlAdl  = strobes[busCtrlPkg::sDlAdl];
	assign dlAdh  = strobes[busCtrlPkg::sDlAdh];
	assign adlAbl = strobes[busCtrlPkg::sAdlAbl];
	assign adhAbh = strobes[busCtrlPkg::sAdhAbh];
	assign zAdh0  = strobes[busCtrlPkg::sZAdh0];
	assign zAdh17 = strobes[busCtrlPkg::sZAdh17];
	assign sbAdh  = strobes[busCtrlPkg::sSbAdh];

endmodule

`default_nettype wire

//--- test/busCtrlVectors.svh
// each test starts with addTest(name, opcode, random stall) and then lists one
// addStep(machine cycle, expected strobes) for every machine cycle it runs.
task automatic loadVectors();
	addTest("ldaImm", cpuDecodePkg::opLdaImm, 1'b0);
	addStep(cpuDecodePkg::T1, mAddr);
	addStep(cpuDecodePkg::T0, mDlDb | mSbAc);
	addTest("andImm", cpuDecodePkg::opAndImm, 1'b0);
	addStep(cpuDecodePkg::T1, mAddr);
	addStep(cpuDecodePkg::T0, mDlDb | mSbAc | mAcSb);
	addTest("implied", cpuDecodePkg::opImp, 1'b0);
	addStep(cpuDecodePkg::T1, mAddr);
	addStep(cpuDecodePkg::T0, mAcSb | mSbAc);
	addTest("ldaZp", cpuDecodePkg::opLdaZp, 1'b0);
	addStep(cpuDecodePkg::T1, mAddr);
	addStep(cpuDecodePkg::T2, mDlAdl | mZAdh0 | mZAdh17 | mAddr);
	addStep(cpuDecodePkg::T0, mDlDb | mSbAc);
	addTest("ldaAbs", cpuDecodePkg::opLdaAbs, 1'b0);
	addStep(cpuDecodePkg::T1, mAddr);
	addStep(cpuDecodePkg::T2, mDlAdl | mAdlAbl);
	addStep(cpuDecodePkg::T3, mDlAdh | mAdhAbh);
	addStep(cpuDecodePkg::T0, mDlDb | mSbAc);
	addTest("staAbs", cpuDecodePkg::opStaAbs, 1'b0);
	addStep(cpuDecodePkg::T1, mAddr);
	addStep(cpuDecodePkg::T2, mDlAdl | mAdlAbl);
	addStep(cpuDecodePkg::T3, mDlAdh | mAdhAbh | mAcDb | mSbDb);
	addStep(cpuDecodePkg::T0, '0);
	addTest("jmpAbs", cpuDecodePkg::opJmpAbs, 1'b0);
	addStep(cpuDecodePkg::T1, mAddr);
	addStep(cpuDecodePkg::T2, mDlAdl | mAdlAbl);
	addStep(cpuDecodePkg::T3, mDlAdh | mAdhAbh | mSbAdh);
	// unknown bytes run as an implied operation.
	addTest("unknownFF", 8'hFF, 1'b0);
	addStep(cpuDecodePkg::T1, mAddr);
	addStep(cpuDecodePkg::T0, mAcSb | mSbAc);
	addTest("unknown00", 8'h00, 1'b0);
	addStep(cpuDecodePkg::T1, mAddr);
	addStep(cpuDecodePkg::T0, mAcSb | mSbAc);
	addTest("ldaZpStall", cpuDecodePkg::opLdaZp, 1'b1);
	addStep(cpuDecodePkg::T1, mAddr);
	addStep(cpuDecodePkg::T2, mDlAdl | mZAdh0 | mZAdh17 | mAddr);
	addStep(cpuDecodePkg::T0, mDlDb | mSbAc);
	addTest("staAbsStall", cpuDecodePkg::opStaAbs, 1'b1);
	addStep(cpuDecodePkg::T1, mAddr);
	addStep(cpuDecodePkg::T2, mDlAdl | mAdlAbl);
	addStep(cpuDecodePkg::T3, mDlAdh | mAdhAbh | mAcDb | mSbDb);
	addStep(cpuDecodePkg::T0, '0);
	addTest("jmpAbsStall", cpuDecodePkg::opJmpAbs, 1'b1);
	addStep(cpuDecodePkg::T1, mAddr);
	addStep(cpuDecodePkg::T2, mDlAdl | mAdlAbl);
	addStep(cpuDecodePkg::T3, mDlAdh | mAdhAbh | mSbAdh);
endtask

//--- test/tbCpuControl.sv
`timescale 1ns/1ps
`default_nettype none

module tbCpuControl;

	localparam int maxTests = 16;
	localparam int maxSteps = 4;
	localparam int syncTimeout = 20;
	localparam int stepTimeout = 16;

	function automatic busCtrlPkg::strobeVec_t strobeBit(input int pos);
		busCtrlPkg::strobeVec_t v;
		v = '0;
		v[0] = 1'b1;
		return v << pos;
	endfunction

	localparam busCtrlPkg::strobeVec_t mSbAc   = strobeBit(busCtrlPkg::sSbAc);
	localparam busCtrlPkg::strobeVec_t mAcSb   = strobeBit(busCtrlPkg::sAcSb);
	localparam busCtrlPkg::strobeVec_t mSbDb   = strobeBit(busCtrlPkg::sSbDb);
	localparam busCtrlPkg::strobeVec_t mAcDb   = strobeBit(busCtrlPkg::sAcDb);
	localparam busCtrlPkg::strobeVec_t mDlDb   = strobeBit(busCtrlPkg::sDlDb);
	localparam busCtrlPkg::strobeVec_t mDlAdl  = strobeBit(busCtrlPkg::sDlAdl);
	localparam busCtrlPkg::strobeVec_t mDlAdh  = strobeBit(busCtrlPkg::sDlAdh);
	localparam busCtrlPkg::strobeVec_t mAdlAbl = strobeBit(busCtrlPkg::sAdlAbl);
	localparam busCtrlPkg::strobeVec_t mAdhAbh = strobeBit(busCtrlPkg::sAdhAbh);
	localparam busCtrlPkg::strobeVec_t mZAdh0  = strobeBit(busCtrlPkg::sZAdh0);
	localparam busCtrlPkg::strobeVec_t mZAdh17 = strobeBit(busCtrlPkg::sZAdh17);
	localparam busCtrlPkg::strobeVec_t mSbAdh  = strobeBit(busCtrlPkg::sSbAdh);
	localparam busCtrlPkg::strobeVec_t mAddr   = mAdlAbl | mAdhAbh;

	logic phi0;
	logic rstN;
	logic ready;
	cpuDecodePkg::opcode_t dataIn;
	logic sbAc;
	logic acSb;
	logic sbDb;
	logic acDb;
	logic dlDb;
	logic dlAdl;
	logic dlAdh;
	logic adlAbl;
	logic adhAbh;
	logic zAdh0;
	logic zAdh17;
	logic sbAdh;
	logic sync;
	cpuDecodePkg::mCycle_e cycle;
	busCtrlPkg::strobeVec_t strobeBus;

	string testName [maxTests];
	cpuDecodePkg::opcode_t testOp [maxTests];
	logic testStall [maxTests];
	int testLen [maxTests];
	cpuDecodePkg::mCycle_e expCycle [maxTests][maxSteps];
	busCtrlPkg::strobeVec_t expStrobe [maxTests][maxSteps];

	int rowCount = 0;
	int seed = 32'hc8d7_6476;
	string curName;
	int testErrors = 0;
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	logic timedOut = 1'b0;
	// lastReady mirrors the DUT's ready latch.
	logic lastReady = 1'b1;

	cpuControlTop cpuControlTop_i (.*);

	always_comb begin
		strobeBus = '0;
		strobeBus[busCtrlPkg::sSbAc]   = sbAc;
		strobeBus[busCtrlPkg::sAcSb]   = acSb;
		strobeBus[busCtrlPkg::sSbDb]   = sbDb;
		strobeBus[busCtrlPkg::sAcDb]   = acDb;
		strobeBus[busCtrlPkg::sDlDb]   = dlDb;
		strobeBus[busCtrlPkg::sDlAdl]  = dlAdl;
		strobeBus[busCtrlPkg::sDlAdh]  = dlAdh;
		strobeBus[busCtrlPkg::sAdlAbl] = adlAbl;
		strobeBus[busCtrlPkg::sAdhAbh] = adhAbh;
		strobeBus[busCtrlPkg::sZAdh0]  = zAdh0;
		strobeBus[busCtrlPkg::sZAdh17] = zAdh17;
		strobeBus[busCtrlPkg::sSbAdh]  = sbAdh;
	end

	initial begin
		phi0 = 1'b0;
		forever #20 phi0 = ~phi0;
	end

	// **************************************************
	// table building, checking and reporting.
	// **************************************************
	task automatic addTest(input string name, input cpuDecodePkg::opcode_t op,
		input logic stall);
		testName[rowCount]  = name;
		testOp[rowCount]    = op;
		testStall[rowCount] = stall;
		testLen[rowCount]   = 0;
		rowCount++;
	endtask

	task automatic addStep(input cpuDecodePkg::mCycle_e cyc,
		input busCtrlPkg::strobeVec_t vec);
		int r;
		r = rowCount - 1;
		expCycle[r][testLen[r]]  = cyc;
		expStrobe[r][testLen[r]] = vec;
		testLen[r]++;
	endtask

	`include "busCtrlVectors.svh"

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s %s expected %0h actual %0h", curName, what,
				expected, actual);
			testErrors++;
			errorCount++;
		end
	endtask

	task automatic reportTest();
		if (testErrors == 0) begin
			passCount++;
			$display("test %s ok", curName);
		end else begin
			failCount++;
			$display("test %s failed with %0d errors", curName, testErrors);
		end
	endtask

	task automatic waitForSync(output logic found);
		int n;
		found = 1'b0;
		n = 0;
		while (!found && n < syncTimeout) begin
			if (sync === 1'b1) begin
				found = 1'b1;
			end else begin
				@(negedge phi0);
				n++;
			end
		end
	endtask

	// steps one instruction at falling edges and a stall repeats the current cycle.
	task automatic runTest(input int t);
		int idx;
		int clocks;
		int stallIdx;
		int stallLeft;
		logic rdy;
		logic found;
		busCtrlPkg::strobeVec_t exp;
		curName = testName[t];
		testErrors = 0;
		stallIdx = -1;
		stallLeft = 0;
		if (testStall[t]) begin
			stallIdx = int'($unsigned($random(seed)) % testLen[t]);
			stallLeft = 1 + int'($unsigned($random(seed)) % 3);
		end
		waitForSync(found);
		if (!found) begin
			$display("timeout waiting for sync before test %s", curName);
			testErrors++;
			errorCount++;
			timedOut = 1'b1;
		end
		idx = 0;
		clocks = 0;
		while (idx < testLen[t] && !timedOut) begin
			checkValue("cycle", 32'(expCycle[t][idx]), 32'(cycle));
			checkValue("sync", 32'(expCycle[t][idx] == cpuDecodePkg::T1), 32'(sync));
			rdy = 1'b1;
			if (idx == stallIdx && stallLeft > 0) begin
				rdy = 1'b0;
				stallLeft--;
			end
			dataIn = testOp[t];
			ready = rdy;
			@(posedge phi0);
			@(negedge phi0);
			exp = expStrobe[t][idx];
			if (!lastReady) begin
				exp = exp & ~mAddr;
			end
			checkValue("strobes", 32'(exp), 32'(strobeBus));
			lastReady = rdy;
			if (rdy) begin
				idx++;
			end
			clocks++;
			if (clocks > stepTimeout) begin
				$display("timeout because test %s never finished its instruction", curName);
				testErrors++;
				errorCount++;
				timedOut = 1'b1;
			end
		end
	endtask

	initial begin
		int t;
		rstN = 1'b0;
		ready = 1'b1;
		dataIn = cpuDecodePkg::opImp;
		loadVectors();
		repeat (8) @(negedge phi0);
		rstN = 1'b1;
		curName = "reset";
		testErrors = 0;
		checkValue("strobes", 32'd0, 32'(strobeBus));
		checkValue("sync", 32'd1, 32'(sync));
		checkValue("cycle", 32'(cpuDecodePkg::T1), 32'(cycle));
		reportTest();
		t = 0;
		while (t < rowCount && !timedOut) begin
			runTest(t);
			reportTest();
			t++;
		end
		$display("tests %0d passed %0d failed %0d errors %0d", passCount + failCount, passCount,
			failCount, errorCount);
		if (errorCount == 0 && !timedOut) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+test
rtl/cpuDecodePkg.sv
rtl/busCtrlPkg.sv
rtl/decodeIf.sv
rtl/timingGen.sv
rtl/decodePla.sv
rtl/busControl.sv
rtl/cpuControlTop.sv
test/tbCpuControl.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, then look for the pass line in the log.
rm -rf obj_dir sim.log
verilator --binary --timing -f flist.f --top-module tbCpuControl -o simv --Mdir obj_dir &&
	./obj_dir/simv > sim.log 2>&1 ||
	{ echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "=== PASS ===" sim.log && echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
